//--- design/fp_sum_pkg.sv
package fp_sum_pkg;

	////////////////////////////////////////
	// Single-precision word
	////////////////////////////////////////

	// Raw word and IEEE field view of the same 32 bits
	typedef union packed {
		logic [31:0] word;
		struct packed {
			logic        sign;
			logic [7:0]  exponent;
			logic [22:0] fraction;
		} f;
	} fp32_u;

	////////////////////////////////////////
	// Internal number format
	////////////////////////////////////////

	// Hidden one, 23 fraction bits, 3 guard bits
	localparam int XMAG_W = 27;

	// Same bias as single precision
	localparam int XEXP_W = 8;

	// Cycles from valid in to valid out of one adder node
	localparam int NODE_LATENCY = 3;

endpackage

//--- design/xnum_if.sv
`timescale 1ns/1ps

interface xnum_if;
	import fp_sum_pkg::*;

	// Single-cycle strobe with no back-pressure
	logic              valid;
	logic              sign;
	logic [XEXP_W-1:0] exponent;
	// Bit 26 set for every nonzero normalized number
	logic [XMAG_W-1:0] magnitude;

	modport src (
		output valid,
		output sign,
		output exponent,
		output magnitude
	);

	modport snk (
		input valid,
		input sign,
		input exponent,
		input magnitude
	);

endinterface

//--- design/sample_collector.sv
`timescale 1ns/1ps

module sample_collector #(
	parameter int NUM_INPUTS = 32
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_valid,
	input  logic [31:0] i_data,
	xnum_if.src         o_leaf [NUM_INPUTS]
);
	import fp_sum_pkg::*;

	// One spare bit so the wrap point is visible to the check below
	localparam int CNT_W = $clog2(NUM_INPUTS) + 1;

	fp32_u             smp;
	logic              u_sign;
	logic [XEXP_W-1:0] u_exp;
	logic [XMAG_W-1:0] u_mag;

	logic              in_valid_q;
	logic              in_sign_q;
	logic [XEXP_W-1:0] in_exp_q;
	logic [XMAG_W-1:0] in_mag_q;

	logic [CNT_W-1:0]  cnt_q;
	logic              rel_q;
	logic              buf_sign [NUM_INPUTS];
	logic [XEXP_W-1:0] buf_exp  [NUM_INPUTS];
	logic [XMAG_W-1:0] buf_mag  [NUM_INPUTS];

	////////////////////////////////////////
	// Unpack with denormals flushed to zero
	////////////////////////////////////////

	assign smp.word = i_data;

	always_comb begin
		if (smp.f.exponent == '0) begin
			u_sign = 1'b0;
			u_exp  = '0;
			u_mag  = '0;
		end else begin
			u_sign = smp.f.sign;
			u_exp  = smp.f.exponent;
			u_mag  = {1'b1, smp.f.fraction, 3'b000};
		end
	end

	// Input stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		in_sign_q <= u_sign;
		in_exp_q  <= u_exp;
		in_mag_q  <= u_mag;
	end

	////////////////////////////////////////
	// Frame buffer and release
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
			rel_q <= 1'b0;
		end else begin
			rel_q <= 1'b0;
			if (in_valid_q) begin
				if (cnt_q == CNT_W'(NUM_INPUTS - 1)) begin
					cnt_q <= '0;
					rel_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_q) begin
			buf_sign[cnt_q[CNT_W-2:0]] <= in_sign_q;
			buf_exp[cnt_q[CNT_W-2:0]]  <= in_exp_q;
			buf_mag[cnt_q[CNT_W-2:0]]  <= in_mag_q;
		end
	end

	// All leaves strobe together
	for (genvar k = 0; k < NUM_INPUTS; k++) begin : g_leaf
		assign o_leaf[k].valid     = rel_q;
		assign o_leaf[k].sign      = buf_sign[k];
		assign o_leaf[k].exponent  = buf_exp[k];
		assign o_leaf[k].magnitude = buf_mag[k];
	end

	cnt_in_range_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		cnt_q < CNT_W'(NUM_INPUTS)
	) else $error("sample counter reached NUM_INPUTS");

endmodule

//--- design/xnum_add_node.sv
`timescale 1ns/1ps

module xnum_add_node (
	input  logic clk,
	input  logic rst_n,
	xnum_if.snk  i_a,
	xnum_if.snk  i_b,
	xnum_if.src  o_sum
);
	import fp_sum_pkg::*;

	localparam int LZ_W = $clog2(XMAG_W);

	// Stage 1 compare and align
	logic              a_big;
	logic              big_sign;
	logic              sml_sign;
	logic [XEXP_W-1:0] big_exp;
	logic [XEXP_W-1:0] sml_exp;
	logic [XEXP_W-1:0] exp_diff;
	logic [XMAG_W-1:0] big_mag;
	logic [XMAG_W-1:0] sml_mag;
	logic [XMAG_W-1:0] sml_aligned;

	logic              s1_valid;
	logic              s1_sign;
	logic              s1_sub;
	logic [XEXP_W-1:0] s1_exp;
	logic [XMAG_W-1:0] s1_big;
	logic [XMAG_W-1:0] s1_sml;

	// Stage 2 add or subtract
	logic              s2_valid;
	logic              s2_sign;
	logic [XEXP_W-1:0] s2_exp;
	logic [XMAG_W:0]   s2_sum;

	// Stage 3 normalize
	logic [LZ_W-1:0]   lz;
	logic              n_sign;
	logic [XEXP_W-1:0] n_exp;
	logic [XMAG_W-1:0] n_mag;

	logic              s3_valid;
	logic              s3_sign;
	logic [XEXP_W-1:0] s3_exp;
	logic [XMAG_W-1:0] s3_mag;

	////////////////////////////////////////
	// Stage 1
	////////////////////////////////////////

	always_comb begin
		// Equal exponents fall back to the magnitudes
		a_big = (i_a.exponent > i_b.exponent) ||
			((i_a.exponent == i_b.exponent) && (i_a.magnitude >= i_b.magnitude));
		if (a_big) begin
			big_sign = i_a.sign;
			big_exp  = i_a.exponent;
			big_mag  = i_a.magnitude;
			sml_sign = i_b.sign;
			sml_exp  = i_b.exponent;
			sml_mag  = i_b.magnitude;
		end else begin
			big_sign = i_b.sign;
			big_exp  = i_b.exponent;
			big_mag  = i_b.magnitude;
			sml_sign = i_a.sign;
			sml_exp  = i_a.exponent;
			sml_mag  = i_a.magnitude;
		end
		exp_diff = big_exp - sml_exp;
		if (exp_diff >= XEXP_W'(XMAG_W)) begin
			sml_aligned = '0;
		end else begin
			sml_aligned = sml_mag >> exp_diff;
		end
	end

	////////////////////////////////////////
	// Stage 3 leading one and underflow
	////////////////////////////////////////

	always_comb begin
		lz = '0;
		// Highest set bit wins
		for (int i = 0; i < XMAG_W; i++) begin
			if (s2_sum[i]) begin
				lz = LZ_W'(XMAG_W - 1 - i);
			end
		end
		n_sign = s2_sign;
		n_exp  = s2_exp - XEXP_W'(lz);
		n_mag  = s2_sum[XMAG_W-1:0] << lz;
		if (s2_sum[XMAG_W]) begin
			// Carry out shifts one place right
			n_exp = s2_exp + 1'b1;
			n_mag = s2_sum[XMAG_W:1];
		end else if ((s2_sum == '0) || (s2_exp <= XEXP_W'(lz))) begin
			n_sign = 1'b0;
			n_exp  = '0;
			n_mag  = '0;
		end
	end

	// Valid chain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else begin
			s1_valid <= i_a.valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
		end
	end

	// Payload pipeline
	always_ff @(posedge clk) begin
		s1_sign <= big_sign;
		s1_sub  <= big_sign ^ sml_sign;
		s1_exp  <= big_exp;
		s1_big  <= big_mag;
		s1_sml  <= sml_aligned;

		s2_sign <= s1_sign;
		s2_exp  <= s1_exp;
		s2_sum  <= s1_sub ? {1'b0, s1_big} - {1'b0, s1_sml}
			: {1'b0, s1_big} + {1'b0, s1_sml};

		s3_sign <= n_sign;
		s3_exp  <= n_exp;
		s3_mag  <= n_mag;
	end

	assign o_sum.valid     = s3_valid;
	assign o_sum.sign      = s3_sign;
	assign o_sum.exponent  = s3_exp;
	assign o_sum.magnitude = s3_mag;

	// Both children come from the same level of the tree
	inputs_aligned_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_a.valid == i_b.valid
	) else $error("adder node operands arrived in different cycles");

	sum_normalized_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		(s3_valid && (s3_mag != '0)) |-> s3_mag[XMAG_W-1]
	) else $error("adder node produced an unnormalized sum");

endmodule

//--- design/fp_pack.sv
`timescale 1ns/1ps

module fp_pack (
	input  logic        clk,
	input  logic        rst_n,
	xnum_if.snk         i_sum,
	output logic        o_valid,
	output logic [31:0] o_data
);
	import fp_sum_pkg::*;

	fp32_u word_d;
	fp32_u word_q;
	logic  valid_q;

	////////////////////////////////////////
	// Truncate and pack
	////////////////////////////////////////

	always_comb begin
		word_d.word = '0;
		if (i_sum.magnitude != '0) begin
			word_d.f.sign     = i_sum.sign;
			word_d.f.exponent = i_sum.exponent;
			// Hidden one and guard bits dropped
			word_d.f.fraction = i_sum.magnitude[XMAG_W-2 -: 23];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_sum.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_sum.valid) begin
			word_q <= word_d;
		end
	end

	assign o_valid = valid_q;
	assign o_data  = word_q.word;

	// Root of the tree must hand over a normalized number
	root_normalized_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		(i_sum.valid && (i_sum.magnitude != '0)) |->
			(i_sum.magnitude[XMAG_W-1] && (i_sum.exponent != '0))
	) else $error("packer received an unnormalized sum");

endmodule

//--- design/fp_tree_sum.sv
`timescale 1ns/1ps

module fp_tree_sum #(
	parameter int NUM_INPUTS = 32
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_valid,
	input  logic [31:0] i_data,
	output logic        o_valid,
	output logic [31:0] o_data
);
	import fp_sum_pkg::*;

	localparam int DEPTH = $clog2(NUM_INPUTS);
	// Leaf strobe to packed output
	localparam int TREE_LATENCY = NODE_LATENCY * DEPTH + 1;

	if ((NUM_INPUTS < 2) || ((1 << DEPTH) != NUM_INPUTS)) begin : g_bad_size
		$error("NUM_INPUTS must be a power of two of at least 2");
	end

	////////////////////////////////////////
	// Heap-numbered links
	////////////////////////////////////////

	// 0 is the root, NUM_INPUTS-1 and up are the leaves
	xnum_if lnk [2*NUM_INPUTS-1] ();

	sample_collector #(
		.NUM_INPUTS (NUM_INPUTS)
	) collector_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_leaf  (lnk[NUM_INPUTS-1:2*NUM_INPUTS-2])
	);

	// Node j adds its two children
	for (genvar j = 0; j < NUM_INPUTS - 1; j++) begin : g_node
		xnum_add_node node_i (
			.clk   (clk),
			.rst_n (rst_n),
			.i_a   (lnk[2*j+1]),
			.i_b   (lnk[2*j+2]),
			.o_sum (lnk[j])
		);
	end

	fp_pack pack_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_sum   (lnk[0]),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

	// Every released frame comes out after the full tree
	frame_latency_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		lnk[NUM_INPUTS-1].valid |-> ##TREE_LATENCY o_valid
	) else $error("frame sum did not appear after the tree latency");

endmodule

//--- include/fp_sum_ref.svh
`ifndef FP_SUM_REF_SVH
`define FP_SUM_REF_SVH

////////////////////////////////////////
// Reference model of the adder tree
////////////////////////////////////////

typedef struct packed {
	logic                            sign;
	logic [fp_sum_pkg::XEXP_W-1:0] exp;
	logic [fp_sum_pkg::XMAG_W-1:0] mag;
} ref_xnum_t;

// Denormals become zero
function automatic ref_xnum_t ref_unpack(input logic [31:0] w);
	fp_sum_pkg::fp32_u u;
	ref_xnum_t         x;
	u.word = w;
	x = '0;
	if (u.f.exponent != '0) begin
		x.sign = u.f.sign;
		x.exp  = u.f.exponent;
		x.mag  = {1'b1, u.f.fraction, 3'b000};
	end
	return x;
endfunction

// One adder node, bit for bit
function automatic ref_xnum_t ref_add(input ref_xnum_t a, input ref_xnum_t b);
	ref_xnum_t   big;
	ref_xnum_t   sml;
	ref_xnum_t   r;
	logic [7:0]  diff;
	logic [26:0] aligned;
	logic [27:0] sum;
	int          lz;
	if ((a.exp > b.exp) || ((a.exp == b.exp) && (a.mag >= b.mag))) begin
		big = a;
		sml = b;
	end else begin
		big = b;
		sml = a;
	end
	diff    = big.exp - sml.exp;
	aligned = (diff >= 8'd27) ? '0 : sml.mag >> diff;
	if (big.sign == sml.sign)
		sum = {1'b0, big.mag} + {1'b0, aligned};
	else
		sum = {1'b0, big.mag} - {1'b0, aligned};
	r.sign = big.sign;
	if (sum == '0)
		return '0;
	if (sum[27]) begin
		r.exp = big.exp + 8'd1;
		r.mag = sum[27:1];
		return r;
	end
	lz = 0;
	while (!sum[26-lz])
		lz++;
	// Underflow flushes to zero
	if (big.exp <= lz)
		return '0;
	r.exp = big.exp - 8'(lz);
	r.mag = sum[26:0] << lz;
	return r;
endfunction

function automatic logic [31:0] ref_pack(input ref_xnum_t x);
	fp_sum_pkg::fp32_u w;
	w.word = '0;
	if (x.mag != '0) begin
		w.f.sign     = x.sign;
		w.f.exponent = x.exp;
		w.f.fraction = x.mag[25:3];
	end
	return w.word;
endfunction

// Whole frame in heap order with leaf k at n-1+k
function automatic logic [31:0] ref_frame_sum(input logic [31:0] smp [$]);
	ref_xnum_t node [];
	int        n;
	n    = smp.size();
	node = new[2*n-1];
	for (int k = 0; k < n; k++)
		node[n-1+k] = ref_unpack(smp[k]);
	for (int j = n - 2; j >= 0; j--)
		node[j] = ref_add(node[2*j+1], node[2*j+2]);
	return ref_pack(node[0]);
endfunction

`endif

//--- tb/tb_fp_tree_sum.sv
`timescale 1ns/1ps

module tb_fp_tree_sum;
	import fp_sum_pkg::*;

	localparam int N_IN    = 32;
	localparam int LATENCY = 2 + NODE_LATENCY * $clog2(N_IN);

	logic        clk;
	logic        rst_n;
	logic        i_valid;
	logic [31:0] i_data;
	logic        o_valid;
	logic [31:0] o_data;

	int          cyc;
	int          n_sent;
	int          n_checked;
	logic [31:0] rng_state;
	logic [31:0] exp_q [$];
	int          due_q [$];

	`include "fp_sum_ref.svh"

	fp_tree_sum #(
		.NUM_INPUTS (N_IN)
	) dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	////////////////////////////////////////
	// Error handling
	////////////////////////////////////////

	task automatic stop_sim();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		stop_sim();
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_sim();
		end
	endtask

	////////////////////////////////////////
	// Random stimulus
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Exponent kept in 100..150
	function automatic logic [31:0] rand_sample();
		logic [31:0] r;
		logic [31:0] fr;
		logic [7:0]  e;
		r  = next_rand();
		fr = next_rand();
		e  = 8'(100 + (r[31:8] % 51));
		return {r[0], e, fr[22:0]};
	endfunction

	task automatic random_frame(output logic [31:0] smp [$]);
		smp = {};
		for (int k = 0; k < N_IN; k++)
			smp.push_back(rand_sample());
	endtask

	////////////////////////////////////////
	// Driver and monitor
	////////////////////////////////////////

	// Expected sum is due LATENCY cycles after the edge taking the last sample
	task automatic send_frame(input logic [31:0] smp [$], input int max_gap);
		logic [31:0] exp_word;
		int          gap;
		exp_word = ref_frame_sum(smp);
		for (int k = 0; k < smp.size(); k++) begin
			@(negedge clk);
			i_valid = 1'b1;
			i_data  = smp[k];
			if (k == smp.size() - 1) begin
				exp_q.push_back(exp_word);
				due_q.push_back(cyc + 1 + LATENCY);
				n_sent++;
			end
			gap = (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0;
			for (int g = 0; g < gap; g++) begin
				@(negedge clk);
				i_valid = 1'b0;
				i_data  = next_rand();
			end
		end
	endtask

	task automatic drive_idle();
		@(negedge clk);
		i_valid = 1'b0;
		i_data  = '0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			n++;
			if (n > 4 * LATENCY)
				abort_run("Timeout: frame sums still pending after the tree latency");
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (o_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("Error: o_valid rose with no frame pending");
			end else begin
				check_equal(32'(cyc), 32'(due_q[0]), "o_valid cycle");
				check_equal(o_data, exp_q[0], "frame sum");
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
				n_checked++;
			end
		end else if ((due_q.size() != 0) && (due_q[0] <= cyc)) begin
			abort_run("Error: o_valid did not rise at the due cycle");
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] smp [$];
		logic [31:0] zeroed [$];
		logic [31:0] x;
		logic [31:0] rs;
		logic [31:0] rf;
		clk       = 1'b0;
		rst_n     = 1'b0;
		i_valid   = 1'b0;
		i_data    = '0;
		cyc       = 0;
		n_sent    = 0;
		n_checked = 0;
		rng_state = 32'h2ef8b6cf;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// Single frame
		random_frame(smp);
		send_frame(smp, 0);
		drive_idle();
		wait_drained();

		// Back to back, valid held high
		for (int f = 0; f < 20; f++) begin
			random_frame(smp);
			send_frame(smp, 0);
		end
		drive_idle();
		wait_drained();

		// Random gaps inside frames
		for (int f = 0; f < 10; f++) begin
			random_frame(smp);
			send_frame(smp, 3);
		end
		drive_idle();
		wait_drained();

		// Pairs x and -x meet in the first level
		smp = {};
		for (int m = 0; m < N_IN / 2; m++) begin
			x = rand_sample();
			smp.push_back(x);
			smp.push_back(x ^ 32'h8000_0000);
		end
		check_equal(ref_frame_sum(smp), 32'h0, "pair frame model");
		send_frame(smp, 1);

		// Every fourth sample denormal
		random_frame(smp);
		zeroed = smp;
		for (int k = 0; k < N_IN; k += 4) begin
			rs        = next_rand();
			rf        = next_rand();
			smp[k]    = {rs[31], 8'h00, rf[22:0] | 23'h1};
			zeroed[k] = 32'h0;
		end
		check_equal(ref_frame_sum(smp), ref_frame_sum(zeroed), "denormal frame model");
		send_frame(smp, 1);
		drive_idle();
		wait_drained();

		// Partial frame thrown away by reset
		for (int k = 0; k < 10; k++) begin
			@(negedge clk);
			i_valid = 1'b1;
			i_data  = rand_sample();
		end
		@(negedge clk);
		i_valid = 1'b0;
		rst_n   = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		repeat (LATENCY) @(negedge clk);
		random_frame(smp);
		send_frame(smp, 2);
		drive_idle();
		wait_drained();

		repeat (5) @(negedge clk);
		if ((n_checked == n_sent) && (exp_q.size() == 0)) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run("Error: number of checked sums differs from frames sent");
		end
	end

endmodule

//--- list.f
+incdir+include
design/fp_sum_pkg.sv
design/xnum_if.sv
design/sample_collector.sv
design/xnum_add_node.sv
design/fp_pack.sv
design/fp_tree_sum.sv
tb/tb_fp_tree_sum.sv

//--- Bender.yml
package:
  name: fp_tree_sum

export_include_dirs:
  - include

sources:
  - files:
      - design/fp_sum_pkg.sv
      - design/xnum_if.sv
      - design/sample_collector.sv
      - design/xnum_add_node.sv
      - design/fp_pack.sv
      - design/fp_tree_sum.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_fp_tree_sum.sv
